// ==== logic/sbusPkg.sv ====
package sbusPkg;

  // Word address as carried on SBUS bits 12 to 35
  // Bit 35 is the least significant bit
  parameter int sbusAdrBits = 24;
  typedef logic [36-sbusAdrBits:35] sbusAdr;

  // Words moved by one quadword request
  parameter int quadWords = 4;

  // Offset of a word inside its quadword
  // These are the low bits of the word address
  parameter int offsetBits = $clog2(quadWords);
  typedef logic [offsetBits-1:0] wordOffset;

  // Request mask, leftmost bit first
  // Bit k asks for the word at (start offset + k) mod 4
  typedef logic [0:quadWords-1] rqMask;

endpackage

// ==== logic/memPkg.sv ====
package memPkg;

  // Core word, numbered 0 to 35 as on the SBUS data lines
  parameter int wordBits = 36;
  typedef logic [0:wordBits-1] memWord;

  // Phase engines, 0 is A and 1 is B
  parameter int phaseCount = 2;

  // Phase engine states
  // ack pulses ackn, read fetches one word
  // shift moves the mask on by one word
  // waitIdle is the closing cycle before the next request
  typedef enum logic [2:0] {
    idle,
    ack,
    read,
    shift,
    waitIdle
  } phaseState;

endpackage

// ==== logic/sbusRequestLatch.sv ====
`timescale 1ns/1ps

module sbusRequestLatch #(
  parameter int addrBits = 8
) (
  input  logic                          SBUS,
  input  logic                          rst,
  input  logic [memPkg::phaseCount-1:0] start,
  input  sbusPkg::rqMask                rq,
  input  sbusPkg::sbusAdr               adr,
  input  logic [memPkg::phaseCount-1:0] engineIdle,
  output logic [memPkg::phaseCount-1:0] reqGo,
  output sbusPkg::rqMask                reqMask [memPkg::phaseCount],
  output logic [addrBits-1:0]           reqAdr [memPkg::phaseCount]
);

  // One pending slot per phase
  for (genvar p = 0; p < memPkg::phaseCount; p++) begin : gSlot
    logic                full;
    sbusPkg::rqMask      maskQ;
    logic [addrBits-1:0] adrQ;

    // Slot is handed over while the engine sits in idle
    assign reqGo[p] = full && engineIdle[p];

    // A new start refills the slot even in the cycle it is taken
    always_ff @(posedge SBUS) begin
      if (rst) begin
        full <= 1'b0;
      end else if (start[p]) begin
        full <= 1'b1;
      end else if (reqGo[p]) begin
        full <= 1'b0;
      end
    end

    // Request payload, sampled with start
    // Only the low addrBits of the word address reach the core
    always_ff @(posedge SBUS) begin
      if (start[p]) begin
        maskQ <= rq;
        adrQ  <= adr[(36 - addrBits) +: addrBits];
      end
    end

    assign reqMask[p] = maskQ;
    assign reqAdr[p]  = adrQ;

    // Master never stacks a second start on a request not yet taken
    assert property (@(posedge SBUS) disable iff (rst)
      start[p] |-> !full || reqGo[p]);

    // Engine leaves idle on the cycle after it takes the slot
    assert property (@(posedge SBUS) disable iff (rst)
      reqGo[p] |=> !engineIdle[p]);
  end

endmodule

// ==== logic/memPhase.sv ====
`timescale 1ns/1ps

module memPhase #(
  parameter int addrBits = 8
) (
  input  logic                SBUS,
  input  logic                rst,
  input  logic                reqGo,
  input  sbusPkg::rqMask      reqMask,
  input  logic [addrBits-1:0] reqAdr,
  output logic                idle,
  output logic                ackn,
  output logic                rdEn,
  output logic [addrBits-1:0] rdAdr,
  output logic                retValid
);

  memPkg::phaseState state;
  memPkg::phaseState next;

  // Words still to be acknowledged
  // Bit 0 is the word at the current offset
  sbusPkg::rqMask toAck;

  // Quadword row held for the whole request
  logic [addrBits-1:sbusPkg::offsetBits] row;

  // Current word offset that wraps inside the quadword
  sbusPkg::wordOffset wo;

  // State register
  always_ff @(posedge SBUS) begin
    if (rst) begin
      state <= memPkg::idle;
    end else begin
      state <= next;
    end
  end

  // Next state
  always_comb begin
    next = state;
    case (state)
      memPkg::idle: begin
        // First word requested goes straight to ack
        if (reqGo) begin
          next = reqMask[0] ? memPkg::ack : memPkg::shift;
        end
      end
      memPkg::ack: begin
        next = memPkg::read;
      end
      memPkg::read: begin
        next = memPkg::shift;
      end
      memPkg::shift: begin
        // Go to ack for the next wanted word
        // Finish when nothing is left after this one
        // Otherwise keep shifting past clear bits
        if (toAck[1]) begin
          next = memPkg::ack;
        end else if (toAck[1:sbusPkg::quadWords-1] == '0) begin
          next = memPkg::waitIdle;
        end
      end
      memPkg::waitIdle: begin
        next = memPkg::idle;
      end
      default: begin
        next = memPkg::idle;
      end
    endcase
  end

  // Request registers
  // Every mask bit gets exactly one shift cycle
  // so the offset steps once per bit whether requested or not
  always_ff @(posedge SBUS) begin
    if (state == memPkg::idle && reqGo) begin
      toAck <= reqMask;
      row   <= reqAdr[addrBits-1:sbusPkg::offsetBits];
      wo    <= reqAdr[sbusPkg::offsetBits-1:0];
    end else if (state == memPkg::shift) begin
      toAck <= {toAck[1:sbusPkg::quadWords-1], 1'b0};
      wo    <= wo + sbusPkg::wordOffset'(1);
    end
  end

  // Moore outputs
  assign idle  = (state == memPkg::idle);
  assign ackn  = (state == memPkg::ack);
  assign rdEn  = (state == memPkg::read);
  assign rdAdr = {row, wo};

  // Store answers one cycle after the read
  always_ff @(posedge SBUS) begin
    if (rst) begin
      retValid <= 1'b0;
    end else begin
      retValid <= rdEn;
    end
  end

  // Each ackn is followed by its own read and never overlaps it
  assert property (@(posedge SBUS) disable iff (rst)
    ackn |-> !rdEn ##1 (rdEn && !ackn));

endmodule

// ==== logic/coreStore.sv ====
`timescale 1ns/1ps

module coreStore #(
  parameter int addrBits = 8
) (
  input  logic                          SBUS,
  input  logic                          loadEn,
  input  logic [addrBits-1:0]           loadAdr,
  input  memPkg::memWord                loadData,
  input  logic [memPkg::phaseCount-1:0] rdEn,
  input  logic [addrBits-1:0]           rdAdr [memPkg::phaseCount],
  output memPkg::memWord                rdData [memPkg::phaseCount]
);

  // Core array
  memPkg::memWord core [2**addrBits];

  // Load port, used to fill the store
  always_ff @(posedge SBUS) begin
    if (loadEn) begin
      core[loadAdr] <= loadData;
    end
  end

  // One registered read port per phase
  // Same-cycle load of the read address still returns the old word
  for (genvar p = 0; p < memPkg::phaseCount; p++) begin : gRead
    memPkg::memWord rdQ;

    // Output holds the last word read until the next read
    always_ff @(posedge SBUS) begin
      if (rdEn[p]) begin
        rdQ <= core[rdAdr[p]];
      end
    end

    assign rdData[p] = rdQ;
  end

endmodule

// ==== logic/sbusReturnMux.sv ====
`timescale 1ns/1ps

module sbusReturnMux (
  input  logic                          SBUS,
  input  logic                          rst,
  input  logic [memPkg::phaseCount-1:0] retValid,
  input  memPkg::memWord                rdData [memPkg::phaseCount],
  output logic [memPkg::phaseCount-1:0] valid,
  output memPkg::memWord                d,
  output logic                          dataPar
);

  // Both phases returning in one cycle
  logic collide;

  // Phase B word parked for one cycle
  logic           holdFull;
  memPkg::memWord holdWord;

  assign collide = retValid[0] && retValid[1];

  always_ff @(posedge SBUS) begin
    if (rst) begin
      holdFull <= 1'b0;
    end else begin
      holdFull <= collide;
    end
  end

  always_ff @(posedge SBUS) begin
    if (collide) begin
      holdWord <= rdData[1];
    end
  end

  // Drive the shared bus
  // The store output register times the bus so a word goes out with retValid
  // A parked B word goes out first
  // Otherwise A wins over B
  always_comb begin
    valid = '0;
    d     = '0;
    if (holdFull) begin
      valid[1] = 1'b1;
      d        = holdWord;
    end else if (retValid[0]) begin
      valid[0] = 1'b1;
      d        = rdData[0];
    end else if (retValid[1]) begin
      valid[1] = 1'b1;
      d        = rdData[1];
    end
  end

  // Even parity over all 36 data lines
  assign dataPar = ^d;

  // Only one valid at a time on the shared data bus
  assert property (@(posedge SBUS) disable iff (rst)
    $onehot0(valid));

  // Engines never return back to back so the parked word finds a free slot
  assert property (@(posedge SBUS) disable iff (rst)
    holdFull |-> retValid == '0);

endmodule

// ==== logic/sbusMemory.sv ====
`timescale 1ns/1ps

module sbusMemory #(
  // Core depth is 2**addrBits words, at least one quadword row
  parameter int addrBits = 8
) (
  input  logic                          SBUS,
  input  logic                          rst,
  input  logic [memPkg::phaseCount-1:0] start,
  input  sbusPkg::rqMask                rq,
  input  sbusPkg::sbusAdr               adr,
  input  logic                          loadEn,
  input  logic [addrBits-1:0]           loadAdr,
  input  memPkg::memWord                loadData,
  output logic [memPkg::phaseCount-1:0] ackn,
  output logic [memPkg::phaseCount-1:0] valid,
  output memPkg::memWord                d,
  output logic                          dataPar
);

  // Latch to engines
  logic [memPkg::phaseCount-1:0] engineIdle;
  logic [memPkg::phaseCount-1:0] reqGo;
  sbusPkg::rqMask                reqMask [memPkg::phaseCount];
  logic [addrBits-1:0]           reqAdr [memPkg::phaseCount];

  // Engines to store
  logic [memPkg::phaseCount-1:0] rdEn;
  logic [addrBits-1:0]           rdAdr [memPkg::phaseCount];

  // Store and engines to return path
  memPkg::memWord                rdData [memPkg::phaseCount];
  logic [memPkg::phaseCount-1:0] retValid;

  sbusRequestLatch #(
    .addrBits(addrBits)
  ) sbusRequestLatch_inst (
    .SBUS      (SBUS),
    .rst       (rst),
    .start     (start),
    .rq        (rq),
    .adr       (adr),
    .engineIdle(engineIdle),
    .reqGo     (reqGo),
    .reqMask   (reqMask),
    .reqAdr    (reqAdr)
  );

  // One engine per SBUS phase, A at index 0
  for (genvar p = 0; p < memPkg::phaseCount; p++) begin : gPhase
    memPhase #(
      .addrBits(addrBits)
    ) memPhase_inst (
      .SBUS    (SBUS),
      .rst     (rst),
      .reqGo   (reqGo[p]),
      .reqMask (reqMask[p]),
      .reqAdr  (reqAdr[p]),
      .idle    (engineIdle[p]),
      .ackn    (ackn[p]),
      .rdEn    (rdEn[p]),
      .rdAdr   (rdAdr[p]),
      .retValid(retValid[p])
    );
  end

  coreStore #(
    .addrBits(addrBits)
  ) coreStore_inst (
    .SBUS    (SBUS),
    .loadEn  (loadEn),
    .loadAdr (loadAdr),
    .loadData(loadData),
    .rdEn    (rdEn),
    .rdAdr   (rdAdr),
    .rdData  (rdData)
  );

  sbusReturnMux sbusReturnMux_inst (
    .SBUS    (SBUS),
    .rst     (rst),
    .retValid(retValid),
    .rdData  (rdData),
    .valid   (valid),
    .d       (d),
    .dataPar (dataPar)
  );

endmodule

// ==== verification/sbusMemoryChecks.svh ====
`ifndef SBUS_MEMORY_CHECKS_SVH
`define SBUS_MEMORY_CHECKS_SVH

// Even parity, XOR of all 36 data lines
function automatic logic parityOf(memPkg::memWord w);
  logic p;
  p = 1'b0;
  for (int i = 0; i < memPkg::wordBits; i++) begin
    p = p ^ w[i];
  end
  return p;
endfunction

// Expected words of one request, in the order the bus returns them
// Mask bit k asks for offset (start + k) mod 4 inside the same row
function automatic wordList expectQuad(sbusPkg::rqMask mask, sbusPkg::sbusAdr a);
  wordList     r;
  int unsigned base;
  int unsigned row;
  int unsigned off;
  base = int'(a) % (1 << addrBits);
  off  = base % sbusPkg::quadWords;
  row  = base - off;
  for (int k = 0; k < sbusPkg::quadWords; k++) begin
    if (mask[k]) begin
      r.push_back(mirror[row + ((off + k) % sbusPkg::quadWords)]);
    end
  end
  return r;
endfunction

task automatic checkWord(string name, memPkg::memWord exp, memPkg::memWord act);
  if (exp !== act) begin
    wordErrors++;
    $display("Error: %s expected %h got %h", name, exp, act);
  end
endtask

task automatic checkPar(string name, logic exp, logic act);
  if (exp !== act) begin
    parErrors++;
    $display("Error: %s expected %h got %h", name, exp, act);
  end
endtask

task automatic checkCount(string name, int exp, int act);
  if (exp != act) begin
    countErrors++;
    $display("Error: %s expected %h got %h", name, exp, act);
  end
endtask

`endif

// ==== verification/sbusMemoryTb.sv ====
`timescale 1ns/1ps

module sbusMemoryTb;

  localparam int addrBits = 8;
  // Directed requests plus the random run
  localparam int requestTotal = 219;

  typedef memPkg::memWord wordList[$];

  logic                          SBUS;
  logic                          rst;
  logic [memPkg::phaseCount-1:0] start;
  sbusPkg::rqMask                rq;
  sbusPkg::sbusAdr               adr;
  logic                          loadEn;
  logic [addrBits-1:0]           loadAdr;
  memPkg::memWord                loadData;
  logic [memPkg::phaseCount-1:0] ackn;
  logic [memPkg::phaseCount-1:0] valid;
  memPkg::memWord                d;
  logic                          dataPar;

  // Copy of what was loaded into the core
  memPkg::memWord mirror [1 << addrBits];
  // Expected returns per phase
  wordList expA;
  wordList expB;
  int acknCount [2];
  int validCount [2];
  int expectedAcks [2];
  // Ack count before the latest request
  // Its first ackn shows the slot is free again
  int lastBase [2];
  int wordErrors;
  int parErrors;
  int countErrors;
  int otherErrors;
  int seed;

  `include "sbusMemoryChecks.svh"

  sbusMemory #(
    .addrBits(addrBits)
  ) sbusMemory_inst (
    .SBUS    (SBUS),
    .rst     (rst),
    .start   (start),
    .rq      (rq),
    .adr     (adr),
    .loadEn  (loadEn),
    .loadAdr (loadAdr),
    .loadData(loadData),
    .ackn    (ackn),
    .valid   (valid),
    .d       (d),
    .dataPar (dataPar)
  );

  initial begin
    SBUS = 1'b0;
    forever #20 SBUS = ~SBUS;
  end

  initial begin
    repeat (requestTotal * 20 + 200) @(posedge SBUS);
    $display("Watchdog expired before all requests were served");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // Scoreboard samples the outputs at the falling edge
  always @(negedge SBUS) begin
    memPkg::memWord exp;
    if (!rst) begin
      for (int p = 0; p < 2; p++) begin
        if (ackn[p]) begin
          acknCount[p]++;
        end
        if (valid[p]) begin
          validCount[p]++;
          if ((p == 0 ? expA.size() : expB.size()) == 0) begin
            otherErrors++;
            $display("Phase %0d returned a word that was never requested", p);
          end else begin
            exp = (p == 0) ? expA.pop_front() : expB.pop_front();
            checkWord($sformatf("d phase %0d", p), exp, d);
            checkPar("dataPar", parityOf(exp), dataPar);
          end
        end
      end
    end
  end

  // One start pulse with the same payload on each selected phase
  task automatic issue(logic [1:0] which, sbusPkg::rqMask m, sbusPkg::sbusAdr a);
    wordList w;
    w = expectQuad(m, a);
    for (int p = 0; p < 2; p++) begin
      if (which[p]) begin
        lastBase[p] = expectedAcks[p];
        expectedAcks[p] += w.size();
        foreach (w[i]) begin
          if (p == 0) begin
            expA.push_back(w[i]);
          end else begin
            expB.push_back(w[i]);
          end
        end
      end
    end
    start = which;
    rq    = m;
    adr   = a;
    @(negedge SBUS);
    start = '0;
  endtask

  // Pending slot is empty once the latest request was acknowledged
  task automatic waitSlot(int p);
    while (acknCount[p] <= lastBase[p]) @(posedge SBUS);
    @(negedge SBUS);
  endtask

  task automatic drain();
    while (expA.size() != 0 || expB.size() != 0) @(posedge SBUS);
    repeat (4) @(negedge SBUS);
    for (int p = 0; p < 2; p++) begin
      checkCount($sformatf("ackn pulses phase %0d", p), expectedAcks[p], acknCount[p]);
      checkCount($sformatf("valid pulses phase %0d", p), expectedAcks[p], validCount[p]);
    end
  endtask

  // Falling edges counted from the one that drives start
  task automatic latencyCheck();
    int ackAt;
    int validAt;
    ackAt   = -1;
    validAt = -1;
    issue(2'b01, 4'b1000, 24'h000013);
    for (int n = 2; n <= 8; n++) begin
      @(negedge SBUS);
      if (ackn[0] && ackAt < 0) begin
        ackAt = n;
      end
      if (valid[0] && validAt < 0) begin
        validAt = n;
      end
    end
    checkCount("ackn latency", 2, ackAt);
    checkCount("valid latency", 4, validAt);
    drain();
  endtask

  initial begin
    int p;
    sbusPkg::rqMask m;
    seed = 32'h3793_605b;
    start = '0;
    rq = '0;
    adr = '0;
    loadEn = 1'b0;
    loadAdr = '0;
    loadData = '0;
    rst = 1'b1;
    lastBase = '{-1, -1};
    repeat (3) @(posedge SBUS);
    @(negedge SBUS);
    rst = 1'b0;
    // Quiet bus after reset
    repeat (4) begin
      @(negedge SBUS);
      checkCount("ackn after reset", 0, int'(ackn));
      checkCount("valid after reset", 0, int'(valid));
    end
    // Fill core with random words
    for (int i = 0; i < (1 << addrBits); i++) begin
      mirror[i] = memPkg::memWord'({$random(seed), $random(seed)});
      loadEn    = 1'b1;
      loadAdr   = addrBits'(i);
      loadData  = mirror[i];
      @(negedge SBUS);
    end
    loadEn = 1'b0;
    checkCount("ackn before first start", 0, acknCount[0] + acknCount[1]);
    latencyCheck();
    // Full quadword at every start offset
    for (int off = 0; off < 4; off++) begin
      issue(2'b01, 4'b1111, 24'h000040 + off);
      drain();
    end
    // Sparse masks
    issue(2'b01, 4'b1010, 24'h000105);
    drain();
    issue(2'b01, 4'b0001, 24'h00020a);
    drain();
    issue(2'b10, 4'b0110, 24'h0000f7);
    drain();
    // Both phases at once so every return collides
    issue(2'b11, 4'b1111, 24'h000031);
    drain();
    // Staggered starts
    for (int s = 1; s < 4; s++) begin
      issue(2'b01, 4'b1111, 24'h000080 + s);
      repeat (s - 1) @(negedge SBUS);
      issue(2'b10, 4'b1011, 24'h0000c0 + s);
      drain();
    end
    // Starts while the engine is busy queue up in order
    issue(2'b01, 4'b1111, 24'h000022);
    waitSlot(0);
    issue(2'b01, 4'b0101, 24'h000047);
    waitSlot(0);
    issue(2'b01, 4'b1001, 24'h00009d);
    drain();
    // Random traffic with a nonempty mask
    repeat (200) begin
      p = $random(seed) & 1;
      m = sbusPkg::rqMask'($random(seed));
      if (m == '0) m = 4'b0100;
      waitSlot(p);
      issue(2'b01 << p, m, sbusPkg::sbusAdr'($random(seed)));
      repeat ($random(seed) & 3) @(negedge SBUS);
    end
    drain();
    $display("Errors: data %0d, parity %0d, count %0d, other %0d",
      wordErrors, parErrors, countErrors, otherErrors);
    if (wordErrors + parErrors + countErrors + otherErrors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+verification
logic/sbusPkg.sv
logic/memPkg.sv
logic/sbusRequestLatch.sv
logic/memPhase.sv
logic/coreStore.sv
logic/sbusReturnMux.sv
logic/sbusMemory.sv
verification/sbusMemoryTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SBUS memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module sbusMemoryTb -f flist.f

out=$(./obj_dir/VsbusMemoryTb)
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
else
  exit 1
fi
